// File: design/decoder_params.svh
`ifndef DECODER_PARAMS_SVH
`define DECODER_PARAMS_SVH

// surface code distances
`define CODE_DISTANCE_X 3
`define CODE_DISTANCE_Z 3

// helpers for derived sizes
`define DECODER_MAX(a, b) (((a) > (b)) ? (a) : (b))
`define DECODER_MAX3(a, b, c) `DECODER_MAX((a), `DECODER_MAX((b), (c)))

// one measurement round per unit of the larger distance
`define MEASUREMENT_ROUNDS `DECODER_MAX(`CODE_DISTANCE_X, `CODE_DISTANCE_Z)
// x, y and round coordinates of a processing unit
`define ADDRESS_WIDTH (3 * $clog2(`MEASUREMENT_ROUNDS))

// minimum dwell per stage, in cycles past entry
`define SPREAD_CLUSTER_DELAY 9
`define SYNC_IS_ODD_CLUSTER_DELAY 9
`define BOUNDARY_GROW_DELAY 3
`define DELAY_COUNTER_WIDTH \
    $clog2(`DECODER_MAX3(`SPREAD_CLUSTER_DELAY, `SYNC_IS_ODD_CLUSTER_DELAY, \
                         `BOUNDARY_GROW_DELAY) + 1)

// quiet window length on the flying level
`define MESSAGE_FLYING_DELAY 4

`define ITERATION_COUNTER_WIDTH 8
`define CYCLE_COUNTER_WIDTH 32

// stall watchdog, 270 cycles for d=3
`define DEADLOCK_THRESHOLD \
    (`CODE_DISTANCE_X * `CODE_DISTANCE_Z * `MEASUREMENT_ROUNDS * 10)
`define STALL_COUNTER_WIDTH ($clog2(`DEADLOCK_THRESHOLD + 1) + 1)

`define COMMAND_FIFO_DEPTH 16

`endif

// File: design/decoder_pkg.sv
`default_nettype none

`include "decoder_params.svh"

package decoder_pkg;

    // controller stages, idle must stay zero
    typedef enum logic [2:0] {
        stage_idle                = 3'd0,
        stage_measurement_loading = 3'd1,
        stage_spread_cluster      = 3'd2,
        stage_sync_is_odd_cluster = 3'd3,
        stage_grow_boundary       = 3'd4,
        stage_result_calculating  = 3'd5
    } stage_t;

    // opcodes understood by the slave controller
    typedef enum logic [2:0] {
        op_advance = 3'd1,
        op_finish  = 3'd2,
        op_abort   = 3'd3
    } opcode_t;

    // link word to the slave, opcode in the low bits
    typedef struct packed {
        logic [`ADDRESS_WIDTH+1:0] reserved;
        opcode_t                   opcode;
    } master_cmd_t;

endpackage

`default_nettype wire

// File: design/flying_window.sv
`timescale 1ns/100ps
`default_nettype none

`include "decoder_params.svh"

module flying_window (
    input  logic clk,
    input  logic reset,
    input  logic downstream_has_message_flying,
    output logic messages_quiet
);

    localparam int DEPTH = `MESSAGE_FLYING_DELAY;

    // last DEPTH samples of the flying level, newest in bit 0
    logic [DEPTH-1:0] flying_history;
    logic [DEPTH-1:0] flying_history_next;

    assign flying_history_next = {flying_history[DEPTH-2:0], downstream_has_message_flying};

    always_ff @(posedge clk) begin
        if (reset) begin
            flying_history <= '0;
            messages_quiet <= 1'b0;
        end else begin
            flying_history <= flying_history_next;
            // quiet only once the whole window is clear
            messages_quiet <= ~|flying_history_next;
        end
    end

    // a flying sample must block quiet on the very next cycle
    a_no_quiet_after_flying: assert property (
        @(posedge clk) disable iff (reset)
        downstream_has_message_flying |=> !messages_quiet
    );

endmodule

`default_nettype wire

// File: design/round_monitor.sv
`timescale 1ns/100ps
`default_nettype none

`include "decoder_params.svh"

module round_monitor (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                new_round_start,
    input  decoder_pkg::stage_t                 stage,
    input  logic                                iteration_done,
    output logic                                stall_exceeded,
    output logic                                deadlock,
    output logic                                result_valid,
    output logic [`ITERATION_COUNTER_WIDTH-1:0] iteration_counter,
    output logic [`CYCLE_COUNTER_WIDTH-1:0]     cycle_counter
);

    localparam int STALL_WIDTH = `STALL_COUNTER_WIDTH;
    localparam logic [STALL_WIDTH-1:0] STALL_LIMIT = STALL_WIDTH'(`DEADLOCK_THRESHOLD);

    logic [STALL_WIDTH-1:0] stall_count;
    logic                   stalling_stage;

    // only comparison against the threshold in the design
    assign stall_exceeded = (stall_count > STALL_LIMIT);

    assign stalling_stage = (stage == decoder_pkg::stage_spread_cluster)
                         || (stage == decoder_pkg::stage_sync_is_odd_cluster);

    // stall watchdog
    always_ff @(posedge clk) begin
        if (reset) begin
            stall_count <= '0;
        end else begin
            case (stage)
                decoder_pkg::stage_spread_cluster,
                decoder_pkg::stage_sync_is_odd_cluster: begin
                    // count carries from spread into sync and sticks past the limit
                    if (!stall_exceeded) begin
                        stall_count <= stall_count + 1'b1;
                    end
                end
                default: begin
                    stall_count <= '0;
                end
            endcase
        end
    end

    // completion and deadlock flags
    always_ff @(posedge clk) begin
        if (reset) begin
            deadlock     <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            if (new_round_start) begin
                deadlock <= 1'b0;
            end else if (stall_exceeded && stalling_stage) begin
                // only a stalled spread or sync stage is a deadlock
                deadlock <= 1'b1;
            end
            if (new_round_start) begin
                result_valid <= 1'b0;
            end else if (stage == decoder_pkg::stage_result_calculating) begin
                // shows up as the stage returns to idle
                result_valid <= 1'b1;
            end
        end
    end

    // per round statistics
    always_ff @(posedge clk) begin
        if (reset) begin
            iteration_counter <= '0;
            cycle_counter     <= '0;
        end else begin
            if (stage == decoder_pkg::stage_measurement_loading) begin
                iteration_counter <= '0;
            end else if (iteration_done) begin
                iteration_counter <= iteration_counter + 1'b1;
            end
            if (stage == decoder_pkg::stage_measurement_loading) begin
                cycle_counter <= 1;
            end else if (!result_valid) begin
                cycle_counter <= cycle_counter + 1'b1;
            end
        end
    end

    // a round ends decoded or aborted but never both
    a_single_round_outcome: assert property (
        @(posedge clk) disable iff (reset)
        !($rose(deadlock) && $rose(result_valid))
    );

endmodule

`default_nettype wire

// File: design/stage_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

`include "decoder_params.svh"

module stage_sequencer (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     new_round_start,
    input  logic                     messages_quiet,
    input  logic                     downstream_has_odd_clusters,
    input  logic                     stall_exceeded,
    output decoder_pkg::stage_t      stage,
    output logic                     iteration_done,
    output logic                     cmd_write,
    output decoder_pkg::master_cmd_t cmd_word
);

    localparam int DW = `DELAY_COUNTER_WIDTH;
    localparam logic [DW-1:0] SPREAD_DELAY = DW'(`SPREAD_CLUSTER_DELAY);
    localparam logic [DW-1:0] SYNC_DELAY   = DW'(`SYNC_IS_ODD_CLUSTER_DELAY);
    localparam logic [DW-1:0] GROW_DELAY   = DW'(`BOUNDARY_GROW_DELAY);

    decoder_pkg::stage_t stage_next;
    logic [DW-1:0]       dwell_count;
    logic [DW-1:0]       dwell_next;

    // transition decisions, the command goes out on the same edge
    always_comb begin
        stage_next      = stage;
        dwell_next      = dwell_count;
        iteration_done  = 1'b0;
        cmd_write       = 1'b0;
        cmd_word.reserved = '0;
        cmd_word.opcode   = decoder_pkg::op_advance;
        case (stage)
            decoder_pkg::stage_idle: begin
                if (new_round_start) begin
                    stage_next = decoder_pkg::stage_measurement_loading;
                    dwell_next = '0;
                    cmd_write  = 1'b1;
                end
            end
            decoder_pkg::stage_measurement_loading: begin
                // single cycle, syndrome comes from an external buffer
                stage_next = decoder_pkg::stage_spread_cluster;
                dwell_next = '0;
            end
            decoder_pkg::stage_spread_cluster: begin
                if (dwell_count == SPREAD_DELAY) begin
                    if (messages_quiet) begin
                        stage_next = decoder_pkg::stage_sync_is_odd_cluster;
                        dwell_next = '0;
                        cmd_write  = 1'b1;
                    end else if (stall_exceeded) begin
                        stage_next      = decoder_pkg::stage_idle;
                        dwell_next      = '0;
                        cmd_write       = 1'b1;
                        cmd_word.opcode = decoder_pkg::op_abort;
                    end
                end else begin
                    dwell_next = dwell_count + 1'b1;
                end
            end
            decoder_pkg::stage_sync_is_odd_cluster: begin
                if (dwell_count == SYNC_DELAY) begin
                    if (messages_quiet) begin
                        iteration_done = 1'b1;
                        dwell_next     = '0;
                        cmd_write      = 1'b1;
                        if (downstream_has_odd_clusters) begin
                            stage_next = decoder_pkg::stage_grow_boundary;
                        end else begin
                            // all clusters even, round is decoded
                            stage_next      = decoder_pkg::stage_result_calculating;
                            cmd_word.opcode = decoder_pkg::op_finish;
                        end
                    end else if (stall_exceeded) begin
                        stage_next      = decoder_pkg::stage_idle;
                        dwell_next      = '0;
                        cmd_write       = 1'b1;
                        cmd_word.opcode = decoder_pkg::op_abort;
                    end
                end else begin
                    dwell_next = dwell_count + 1'b1;
                end
            end
            decoder_pkg::stage_grow_boundary: begin
                // fixed length, no quiet check
                if (dwell_count == GROW_DELAY) begin
                    stage_next = decoder_pkg::stage_spread_cluster;
                    dwell_next = '0;
                    cmd_write  = 1'b1;
                end else begin
                    dwell_next = dwell_count + 1'b1;
                end
            end
            decoder_pkg::stage_result_calculating: begin
                stage_next = decoder_pkg::stage_idle;
                dwell_next = '0;
            end
            default: begin
                stage_next = decoder_pkg::stage_idle;
                dwell_next = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage       <= decoder_pkg::stage_idle;
            dwell_count <= '0;
        end else begin
            stage       <= stage_next;
            dwell_count <= dwell_next;
        end
    end

    // loading and result stages are silent toward the slave
    a_no_cmd_in_silent_stage: assert property (
        @(posedge clk) disable iff (reset)
        cmd_write |-> !(stage inside {decoder_pkg::stage_measurement_loading,
                                      decoder_pkg::stage_result_calculating})
    );

    // encodings 6 and 7 never reached
    a_stage_legal: assert property (
        @(posedge clk) disable iff (reset)
        stage inside {decoder_pkg::stage_idle, decoder_pkg::stage_measurement_loading,
                      decoder_pkg::stage_spread_cluster,
                      decoder_pkg::stage_sync_is_odd_cluster,
                      decoder_pkg::stage_grow_boundary,
                      decoder_pkg::stage_result_calculating}
    );

endmodule

`default_nettype wire

// File: design/command_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "decoder_params.svh"

module command_fifo (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     cmd_write,
    input  decoder_pkg::master_cmd_t cmd_word,
    input  logic                     cmd_out_ready,
    output decoder_pkg::master_cmd_t cmd_out_data,
    output logic                     cmd_out_valid
);

    localparam int DEPTH       = `COMMAND_FIFO_DEPTH;
    localparam int PTR_WIDTH   = $clog2(DEPTH);
    localparam int COUNT_WIDTH = $clog2(DEPTH + 1);
    localparam logic [PTR_WIDTH-1:0]   LAST_SLOT = PTR_WIDTH'(DEPTH - 1);
    localparam logic [COUNT_WIDTH-1:0] FULL_COUNT = COUNT_WIDTH'(DEPTH);

    decoder_pkg::master_cmd_t storage [DEPTH];

    logic [PTR_WIDTH-1:0]   wr_ptr;
    logic [PTR_WIDTH-1:0]   rd_ptr;
    logic [COUNT_WIDTH-1:0] occupancy;
    logic                   pop;

    // head word shown directly, fall-through
    assign cmd_out_valid = (occupancy != '0);
    assign cmd_out_data  = storage[rd_ptr];
    assign pop           = cmd_out_valid && cmd_out_ready;

    // payload memory
    always_ff @(posedge clk) begin
        if (cmd_write) begin
            storage[wr_ptr] <= cmd_word;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
        end else begin
            if (cmd_write) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            if (cmd_write && !pop) begin
                occupancy <= occupancy + 1'b1;
            end else if (pop && !cmd_write) begin
                occupancy <= occupancy - 1'b1;
            end
        end
    end

    // sequencer never stalls, so the slave must keep up
    a_no_write_when_full: assert property (
        @(posedge clk) disable iff (reset)
        cmd_write |-> (occupancy != FULL_COUNT)
    );

endmodule

`default_nettype wire

// File: design/decoder_master.sv
`timescale 1ns/100ps
`default_nettype none

`include "decoder_params.svh"

module decoder_master (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                new_round_start,
    input  logic                                downstream_has_message_flying,
    input  logic                                downstream_has_odd_clusters,
    input  logic                                cmd_out_ready,
    output decoder_pkg::master_cmd_t            cmd_out_data,
    output logic                                cmd_out_valid,
    output logic                                result_valid,
    output logic                                deadlock,
    output logic [`ITERATION_COUNTER_WIDTH-1:0] iteration_counter,
    output logic [`CYCLE_COUNTER_WIDTH-1:0]     cycle_counter
);

    logic                     messages_quiet;
    logic                     stall_exceeded;
    logic                     iteration_done;
    logic                     cmd_write;
    decoder_pkg::stage_t      stage;
    decoder_pkg::master_cmd_t cmd_word;

    // downstream activity window
    flying_window i_flying_window (
        .clk                           (clk),
        .reset                         (reset),
        .downstream_has_message_flying (downstream_has_message_flying),
        .messages_quiet                (messages_quiet)
    );

    stage_sequencer i_stage_sequencer (
        .clk                         (clk),
        .reset                       (reset),
        .new_round_start             (new_round_start),
        .messages_quiet              (messages_quiet),
        .downstream_has_odd_clusters (downstream_has_odd_clusters),
        .stall_exceeded              (stall_exceeded),
        .stage                       (stage),
        .iteration_done              (iteration_done),
        .cmd_write                   (cmd_write),
        .cmd_word                    (cmd_word)
    );

    // statistics and watchdog off the stage trace
    round_monitor i_round_monitor (
        .clk               (clk),
        .reset             (reset),
        .new_round_start   (new_round_start),
        .stage             (stage),
        .iteration_done    (iteration_done),
        .stall_exceeded    (stall_exceeded),
        .deadlock          (deadlock),
        .result_valid      (result_valid),
        .iteration_counter (iteration_counter),
        .cycle_counter     (cycle_counter)
    );

    // outbound link to the slave controller
    command_fifo i_command_fifo (
        .clk           (clk),
        .reset         (reset),
        .cmd_write     (cmd_write),
        .cmd_word      (cmd_word),
        .cmd_out_ready (cmd_out_ready),
        .cmd_out_data  (cmd_out_data),
        .cmd_out_valid (cmd_out_valid)
    );

endmodule

`default_nettype wire

// File: test/tb_decoder_master.sv
`timescale 1ns/100ps
`default_nettype none

`include "decoder_params.svh"

module tb_decoder_master;

    localparam int unsigned SEED = 32'h4c02_459b;

    // expected outcome of one decoded round
    typedef struct packed {
        logic [15:0][2:0]                    opcodes;
        logic [4:0]                          word_count;
        logic [`ITERATION_COUNTER_WIDTH-1:0] iterations;
        logic [`CYCLE_COUNTER_WIDTH-1:0]     cycles;
    } round_ref_t;

    logic                                clk;
    logic                                reset;
    logic                                new_round_start;
    logic                                downstream_has_message_flying;
    logic                                downstream_has_odd_clusters;
    logic                                cmd_out_ready;
    decoder_pkg::master_cmd_t            cmd_out_data;
    logic                                cmd_out_valid;
    logic                                result_valid;
    logic                                deadlock;
    logic [`ITERATION_COUNTER_WIDTH-1:0] iteration_counter;
    logic [`CYCLE_COUNTER_WIDTH-1:0]     cycle_counter;

    // 0 silent, 1 random bursts, 2 held high
    int                       flying_mode;
    int                       odd_target;
    int                       odd_count;
    decoder_pkg::master_cmd_t expected_words [$];

    decoder_master i_dut (
        .clk                           (clk),
        .reset                         (reset),
        .new_round_start               (new_round_start),
        .downstream_has_message_flying (downstream_has_message_flying),
        .downstream_has_odd_clusters   (downstream_has_odd_clusters),
        .cmd_out_ready                 (cmd_out_ready),
        .cmd_out_data                  (cmd_out_data),
        .cmd_out_valid                 (cmd_out_valid),
        .result_valid                  (result_valid),
        .deadlock                      (deadlock),
        .iteration_counter             (iteration_counter),
        .cycle_counter                 (cycle_counter)
    );

    always #5 clk = ~clk;

    task automatic stop_on_mismatch(input string name, input logic [63:0] expected,
                                    input logic [63:0] actual);
        $display("MISMATCH time=%0t signal=%s expected=0x%0h actual=0x%0h",
                 $time, name, expected, actual);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic stop_with_error(input string what);
        $display("ERROR time=%0t %s", $time, what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else stop_on_mismatch(name, expected, actual);
    endtask

    // inputs change 1 ns past the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // opcode list, iteration count and no-flying cycle count of one round
    function automatic round_ref_t reference_round(input int odd_iterations);
        round_ref_t r;
        int         n;
        int         spread_len;
        int         sync_len;
        int         grow_len;
        r = '0;
        n = 0;
        spread_len = `SPREAD_CLUSTER_DELAY + 1;
        sync_len = `SYNC_IS_ODD_CLUSTER_DELAY + 1;
        grow_len = `BOUNDARY_GROW_DELAY + 1;
        // start of round
        r.opcodes[n] = decoder_pkg::op_advance;
        n = n + 1;
        // spread exit, sync exit, grow exit
        for (int i = 0; i < odd_iterations; i++) begin
            r.opcodes[n] = decoder_pkg::op_advance;
            r.opcodes[n+1] = decoder_pkg::op_advance;
            r.opcodes[n+2] = decoder_pkg::op_advance;
            n = n + 3;
        end
        // last spread, then the finishing sync
        r.opcodes[n] = decoder_pkg::op_advance;
        r.opcodes[n+1] = decoder_pkg::op_finish;
        n = n + 2;
        r.word_count = 5'(n);
        r.iterations = `ITERATION_COUNTER_WIDTH'(odd_iterations + 1);
        // loaded with 1, then one count per stage cycle, result stage included
        r.cycles = `CYCLE_COUNTER_WIDTH'(1 + spread_len + sync_len
            + odd_iterations * (grow_len + spread_len + sync_len) + 1);
        return r;
    endfunction

    task automatic expect_opcode(input decoder_pkg::opcode_t opcode);
        decoder_pkg::master_cmd_t word;
        word.reserved = '0;
        word.opcode = opcode;
        expected_words.push_back(word);
    endtask

    task automatic wait_for_result(input int limit);
        int waited;
        waited = 0;
        while (!result_valid && waited < limit) begin
            next_cycle();
            waited = waited + 1;
        end
        assert (result_valid) else stop_with_error("result_valid never rose, round timed out");
    endtask

    task automatic wait_for_deadlock(input int limit);
        int waited;
        waited = 0;
        while (!deadlock && waited < limit) begin
            next_cycle();
            waited = waited + 1;
        end
        assert (deadlock) else stop_with_error("deadlock never rose under held flying");
    endtask

    task automatic wait_for_drain(input int limit);
        int waited;
        waited = 0;
        while (expected_words.size() != 0 && waited < limit) begin
            next_cycle();
            waited = waited + 1;
        end
        assert (expected_words.size() == 0)
            else stop_with_error("expected command words never left the FIFO");
    endtask

    task automatic start_round();
        new_round_start = 1'b1;
        next_cycle();
        new_round_start = 1'b0;
        // start clears both flags
        check_value("deadlock", 0, deadlock);
        check_value("result_valid", 0, result_valid);
    endtask

    task automatic run_round(input int odd_iterations, input bit bursts,
                             input bit check_cycles, input bit hold_ready);
        round_ref_t expected;
        expected = reference_round(odd_iterations);
        for (int i = 0; i < int'(expected.word_count); i++) begin
            expect_opcode(decoder_pkg::opcode_t'(expected.opcodes[i]));
        end
        odd_target = odd_iterations;
        flying_mode = bursts ? 1 : 0;
        cmd_out_ready = !hold_ready;
        start_round();
        wait_for_result(2000);
        flying_mode = 0;
        check_value("deadlock", 0, deadlock);
        check_value("iteration_counter", 64'(expected.iterations), 64'(iteration_counter));
        if (check_cycles) begin
            check_value("cycle_counter", 64'(expected.cycles), 64'(cycle_counter));
        end
        if (hold_ready) begin
            // whole round still parked in the FIFO
            check_value("cmd_out_valid", 1, cmd_out_valid);
            cmd_out_ready = 1'b1;
        end
        wait_for_drain(64);
        repeat (`MESSAGE_FLYING_DELAY + 2) next_cycle();
    endtask

    // flying held past the watchdog, round must abort
    task automatic run_deadlock_round();
        expect_opcode(decoder_pkg::op_advance);
        expect_opcode(decoder_pkg::op_abort);
        odd_target = 0;
        flying_mode = 2;
        repeat (2) next_cycle();
        start_round();
        wait_for_deadlock(`DEADLOCK_THRESHOLD + 100);
        check_value("result_valid", 0, result_valid);
        flying_mode = 0;
        wait_for_drain(64);
        check_value("deadlock", 1, deadlock);
        check_value("iteration_counter", 0, 64'(iteration_counter));
        repeat (`MESSAGE_FLYING_DELAY + 2) next_cycle();
    endtask

    // downstream model, mode read at the edge and levels driven 1 ns later
    initial begin : downstream_model
        int mode;
        int target;
        int remaining;
        remaining = 0;
        forever begin
            @(posedge clk);
            mode = flying_mode;
            target = odd_target;
            #1;
            // odd clusters left until target sync exits have gone by
            downstream_has_odd_clusters = (int'(iteration_counter) < target);
            if (mode == 2) begin
                downstream_has_message_flying = 1'b1;
            end else if (mode == 1) begin
                if (remaining == 0) begin
                    downstream_has_message_flying = ~downstream_has_message_flying;
                    // gaps of 4+ cycles let the quiet window open
                    remaining = downstream_has_message_flying ? int'($urandom_range(6, 1))
                                                              : int'($urandom_range(12, 4));
                end
                remaining = remaining - 1;
            end else begin
                downstream_has_message_flying = 1'b0;
                remaining = 0;
            end
        end
    end

    // a pop happens on the next rising edge, so compare at the falling one
    always @(negedge clk) begin
        if (!reset && cmd_out_valid && cmd_out_ready) begin
            assert (expected_words.size() != 0)
                else stop_with_error("command word appeared when none was expected");
            assert (cmd_out_data === expected_words[0])
                else stop_on_mismatch("cmd_out_data", 64'(expected_words[0]), 64'(cmd_out_data));
            void'(expected_words.pop_front());
        end
    end

    initial begin : stimulus
        void'($urandom(SEED));
        clk = 1'b0;
        reset = 1'b1;
        new_round_start = 1'b0;
        downstream_has_message_flying = 1'b0;
        downstream_has_odd_clusters = 1'b0;
        cmd_out_ready = 1'b1;
        flying_mode = 0;
        odd_target = 0;
        repeat (8) next_cycle();
        reset = 1'b0;
        // state straight out of reset
        check_value("result_valid", 0, result_valid);
        check_value("deadlock", 0, deadlock);
        check_value("cmd_out_valid", 0, cmd_out_valid);
        check_value("iteration_counter", 0, 64'(iteration_counter));
        check_value("cycle_counter", 0, 64'(cycle_counter));
        repeat (2) next_cycle();
        run_round(0, 0, 1, 0);
        repeat (4) begin
            odd_count = int'($urandom_range(4, 0));
            run_round(odd_count, 0, 1, 0);
        end
        // bursts only stretch stages
        repeat (4) begin
            odd_count = int'($urandom_range(4, 0));
            run_round(odd_count, 1, 0, 0);
        end
        run_deadlock_round();
        run_round(int'($urandom_range(4, 0)), 0, 1, 0);
        // at most 12 words under back-pressure
        run_round(int'($urandom_range(3, 0)), 0, 1, 1);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+design
design/decoder_pkg.sv
design/flying_window.sv
design/round_monitor.sv
design/stage_sequencer.sv
design/command_fifo.sv
design/decoder_master.sv
test/tb_decoder_master.sv

// File: Makefile
VERILATOR    ?= verilator
TOP          ?= tb_decoder_master
FILE_LIST    ?= verilog.f
BUILD_DIR    ?= obj_dir
LOG          ?= sim.log
FAIL_MESSAGE ?= Simulation failed
VFLAGS       ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal

SOURCES := $(wildcard design/*.sv design/*.svh test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: compile
	@$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MESSAGE)" $(LOG); then \
		echo "run failed, see $(LOG)"; exit 1; \
	fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)
